// ==== design/alu_data_pkg.sv ====
package alu_data_pkg;

    // Every operand and result in the lane is one single-precision word
    typedef logic [31:0] word_t;

    // Destination register address that travels with each instruction
    typedef logic [7:0] reg_addr_t;

    // Bit position for BSEL, BSET and BCLR, taken from the low bits of operand b
    typedef logic [4:0] bit_index_t;

endpackage

// ==== design/alu_isa_pkg.sv ====
package alu_isa_pkg;

    // Opcode encoding of the execution lane
    typedef enum logic [4:0] {
        NOP    = 5'd0,
        LDR    = 5'd1,
        LDC    = 5'd2,
        BGT    = 5'd3,
        BLE    = 5'd4,
        BEQ    = 5'd5,
        BNE    = 5'd6,
        SATP   = 5'd7,
        SATN   = 5'd8,
        LAND   = 5'd9,
        LOR    = 5'd10,
        LXOR   = 5'd11,
        LNOT   = 5'd12,
        POPCNT = 5'd13,
        ABS    = 5'd14,
        BSEL   = 5'd15,
        BSET   = 5'd16,
        BCLR   = 5'd17
    } opcode_t;

    // Operations handled by the single-stage bitwise unit
    function automatic logic is_bitwise_op(opcode_t op);
        case (op)
            LDR, LDC, LAND, LOR, LXOR, LNOT, POPCNT, ABS, BSEL, BSET, BCLR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Operations that need the sign-magnitude ordering of a and b
    function automatic logic is_compare_op(opcode_t op);
        case (op)
            BGT, BLE, BEQ, BNE, SATP, SATN: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

// ==== design/delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
    parameter int DEPTH = 1
) (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   advance,
    input  logic                   in_valid,
    input  alu_data_pkg::word_t     in_data,
    input  alu_data_pkg::reg_addr_t in_dest,
    output logic                   out_valid,
    output alu_data_pkg::word_t     out_data,
    output alu_data_pkg::reg_addr_t out_dest
);

    logic [DEPTH-1:0]        valid_q;
    alu_data_pkg::word_t     data_q [DEPTH];
    alu_data_pkg::reg_addr_t dest_q [DEPTH];

    // Valid bits shift one place toward the output on every advance
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            data_q[0] <= in_data;
            dest_q[0] <= in_dest;
            for (int i = 1; i < DEPTH; i++) begin
                data_q[i] <= data_q[i-1];
                dest_q[i] <= dest_q[i-1];
            end
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_data  = data_q[DEPTH-1];
    assign out_dest  = dest_q[DEPTH-1];

endmodule

// ==== design/bitwise_unit.sv ====
`timescale 1ns/1ps

module bitwise_unit #(
    parameter int PIPELINE_DEPTH = 5
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    advance,
    input  logic                    in_valid,
    input  alu_isa_pkg::opcode_t    op_code,
    input  alu_data_pkg::word_t     operand_a,
    input  alu_data_pkg::word_t     operand_b,
    input  alu_data_pkg::reg_addr_t in_dest,
    output logic                    unit_valid,
    output alu_data_pkg::word_t     unit_data,
    output alu_data_pkg::reg_addr_t unit_dest
);

    alu_data_pkg::bit_index_t bit_idx;
    alu_data_pkg::word_t      bit_mask;
    alu_data_pkg::word_t      next_data;
    logic [5:0]               ones;

    logic                    stage_valid;
    alu_data_pkg::word_t     stage_data;
    alu_data_pkg::reg_addr_t stage_dest;

    // Only the low five bits of b address a bit in the word
    assign bit_idx  = operand_b[4:0];
    assign bit_mask = 32'd1 << bit_idx;

    always_comb begin
        ones = '0;
        for (int i = 0; i < 32; i++) begin
            ones = ones + 6'(operand_a[i]);
        end
    end

    always_comb begin
        case (op_code)
            alu_isa_pkg::LDR:    next_data = operand_a;
            alu_isa_pkg::LDC:    next_data = operand_b;
            alu_isa_pkg::LAND:   next_data = operand_a & operand_b;
            alu_isa_pkg::LOR:    next_data = operand_a | operand_b;
            alu_isa_pkg::LXOR:   next_data = operand_a ^ operand_b;
            alu_isa_pkg::LNOT:   next_data = ~operand_a;
            alu_isa_pkg::POPCNT: next_data = {26'd0, ones};
            // Float absolute value only drops the sign bit
            alu_isa_pkg::ABS:    next_data = {1'b0, operand_a[30:0]};
            alu_isa_pkg::BSEL:   next_data = {31'd0, operand_a[bit_idx]};
            alu_isa_pkg::BSET:   next_data = operand_a | bit_mask;
            alu_isa_pkg::BCLR:   next_data = operand_a & ~bit_mask;
            default:             next_data = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            stage_valid <= 1'b0;
        end else if (advance) begin
            stage_valid <= in_valid && alu_isa_pkg::is_bitwise_op(op_code);
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            stage_data <= next_data;
            stage_dest <= in_dest;
        end
    end

    // The remaining depth lines this unit up with the compare unit
    delay_line #(
        .DEPTH(PIPELINE_DEPTH - 1)
    ) align (
        .clock    (clock),
        .rst_n    (rst_n),
        .advance  (advance),
        .in_valid (stage_valid),
        .in_data  (stage_data),
        .in_dest  (stage_dest),
        .out_valid(unit_valid),
        .out_data (unit_data),
        .out_dest (unit_dest)
    );

    // A claimed instruction must leave the stage with defined operands behind it
    stage_known: assert property (@(posedge clock) disable iff (!rst_n)
        stage_valid |-> !$isunknown({stage_data, stage_dest}));

endmodule

// ==== design/float_compare_unit.sv ====
`timescale 1ns/1ps

module float_compare_unit #(
    parameter int PIPELINE_DEPTH = 5
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    advance,
    input  logic                    in_valid,
    input  alu_isa_pkg::opcode_t    op_code,
    input  alu_data_pkg::word_t     operand_a,
    input  alu_data_pkg::word_t     operand_b,
    input  alu_data_pkg::reg_addr_t in_dest,
    output logic                    unit_valid,
    output alu_data_pkg::word_t     unit_data,
    output alu_data_pkg::reg_addr_t unit_dest
);

    logic        a_neg;
    logic        b_neg;
    logic [30:0] a_mag;
    logic [30:0] b_mag;
    logic        a_less;
    logic        a_equal;

    alu_data_pkg::word_t     a_key;
    alu_data_pkg::word_t     b_key;

    logic                    s1_valid;
    logic                    s1_less;
    logic                    s1_equal;
    alu_isa_pkg::opcode_t    s1_op;
    alu_data_pkg::word_t     s1_a;
    alu_data_pkg::word_t     s1_b;
    alu_data_pkg::reg_addr_t s1_dest;

    logic                    s1_greater;
    alu_data_pkg::word_t     s2_next;
    logic                    s2_valid;
    alu_data_pkg::word_t     s2_data;
    alu_data_pkg::reg_addr_t s2_dest;

    assign a_neg = operand_a[31];
    assign b_neg = operand_b[31];
    assign a_mag = operand_a[30:0];
    assign b_mag = operand_b[30:0];

    // Sign-magnitude ordering in which +0 and -0 are the same number
    always_comb begin
        a_less  = 1'b0;
        a_equal = 1'b0;
        if (a_mag == '0 && b_mag == '0) begin
            a_equal = 1'b1;
        end else if (a_neg != b_neg) begin
            a_less = a_neg;
        end else if (a_mag == b_mag) begin
            a_equal = 1'b1;
        end else if (a_neg) begin
            // When both are negative the larger magnitude is the smaller value
            a_less = a_mag > b_mag;
        end else begin
            a_less = a_mag < b_mag;
        end
    end

    // Flipping negative words and marking positive ones gives keys that order as unsigned
    assign a_key = a_neg ? ~operand_a : {1'b1, a_mag};
    assign b_key = b_neg ? ~operand_b : {1'b1, b_mag};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid && alu_isa_pkg::is_compare_op(op_code);
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            s1_less  <= a_less;
            s1_equal <= a_equal;
            s1_op    <= op_code;
            s1_a     <= operand_a;
            s1_b     <= operand_b;
            s1_dest  <= in_dest;
            s2_data  <= s2_next;
            s2_dest  <= s1_dest;
        end
    end

    assign s1_greater = !s1_less && !s1_equal;

    // Branch flags are 0 or 1 and saturation picks one operand, keeping a on a tie
    always_comb begin
        case (s1_op)
            alu_isa_pkg::BGT:  s2_next = {31'd0, s1_greater};
            alu_isa_pkg::BLE:  s2_next = {31'd0, !s1_greater};
            alu_isa_pkg::BEQ:  s2_next = {31'd0, s1_equal};
            alu_isa_pkg::BNE:  s2_next = {31'd0, !s1_equal};
            alu_isa_pkg::SATP: s2_next = s1_greater ? s1_b : s1_a;
            alu_isa_pkg::SATN: s2_next = s1_less ? s1_b : s1_a;
            default:           s2_next = '0;
        endcase
    end

    delay_line #(
        .DEPTH(PIPELINE_DEPTH - 2)
    ) align (
        .clock    (clock),
        .rst_n    (rst_n),
        .advance  (advance),
        .in_valid (s2_valid),
        .in_data  (s2_data),
        .in_dest  (s2_dest),
        .out_valid(unit_valid),
        .out_data (unit_data),
        .out_dest (unit_dest)
    );

    // Apart from two zeros, the ordering must agree with an unsigned compare of the keys
    order_check: assert property (@(posedge clock) disable iff (!rst_n)
        (in_valid && (a_mag != '0 || b_mag != '0))
            |-> (a_less == (a_key < b_key)) && (a_equal == (a_key == b_key)));

endmodule

// ==== design/writeback_select.sv ====
`timescale 1ns/1ps

module writeback_select (
    input  logic                    clock,
    input  logic                    bit_valid,
    input  logic                    cmp_valid,
    input  alu_data_pkg::word_t     bit_data,
    input  alu_data_pkg::word_t     cmp_data,
    input  alu_data_pkg::reg_addr_t bit_dest,
    input  alu_data_pkg::reg_addr_t cmp_dest,
    output logic                    result_valid,
    output alu_data_pkg::word_t     result_data,
    output alu_data_pkg::reg_addr_t result_dest
);

    alu_data_pkg::word_t     bit_data_gated;
    alu_data_pkg::word_t     cmp_data_gated;
    alu_data_pkg::reg_addr_t bit_dest_gated;
    alu_data_pkg::reg_addr_t cmp_dest_gated;

    // Each unit only contributes while its own valid is high
    assign bit_data_gated = bit_valid ? bit_data : '0;
    assign cmp_data_gated = cmp_valid ? cmp_data : '0;
    assign bit_dest_gated = bit_valid ? bit_dest : '0;
    assign cmp_dest_gated = cmp_valid ? cmp_dest : '0;

    // With at most one unit valid, an OR of the gated words is the selected word
    assign result_valid = bit_valid | cmp_valid;
    assign result_data  = bit_data_gated | cmp_data_gated;
    assign result_dest  = bit_dest_gated | cmp_dest_gated;

    // Equal unit latency and disjoint opcode groups keep the valids one-hot
    unit_exclusive: assert property (@(posedge clock)
        $onehot0({bit_valid, cmp_valid}));

endmodule

// ==== design/exec_lane.sv ====
`timescale 1ns/1ps

module exec_lane #(
    parameter int PIPELINE_DEPTH = 5
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    op_valid,
    input  alu_isa_pkg::opcode_t    op_code,
    input  alu_data_pkg::word_t     operand_a,
    input  alu_data_pkg::word_t     operand_b,
    input  alu_data_pkg::reg_addr_t op_dest,
    output logic                    op_ready,
    output logic                    result_valid,
    output alu_data_pkg::word_t     result_data,
    output alu_data_pkg::reg_addr_t result_dest,
    input  logic                    result_ready
);

    logic                    advance;
    logic                    issue;
    logic                    bit_valid;
    alu_data_pkg::word_t     bit_data;
    alu_data_pkg::reg_addr_t bit_dest;
    logic                    cmp_valid;
    alu_data_pkg::word_t     cmp_data;
    alu_data_pkg::reg_addr_t cmp_dest;

    // The compare unit needs two stages plus at least one alignment register
    if (PIPELINE_DEPTH < 3) begin : g_depth_check
        $error("exec_lane needs PIPELINE_DEPTH of at least 3");
    end

    // The whole lane stalls together and moves only when writeback can take a result
    assign advance  = result_ready;
    assign op_ready = result_ready;
    assign issue    = op_valid && op_ready;

    bitwise_unit #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) bit_unit (
        .clock     (clock),
        .rst_n     (rst_n),
        .advance   (advance),
        .in_valid  (issue),
        .op_code   (op_code),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .in_dest   (op_dest),
        .unit_valid(bit_valid),
        .unit_data (bit_data),
        .unit_dest (bit_dest)
    );

    float_compare_unit #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) cmp_unit (
        .clock     (clock),
        .rst_n     (rst_n),
        .advance   (advance),
        .in_valid  (issue),
        .op_code   (op_code),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .in_dest   (op_dest),
        .unit_valid(cmp_valid),
        .unit_data (cmp_data),
        .unit_dest (cmp_dest)
    );

    writeback_select wb_sel (
        .clock       (clock),
        .bit_valid   (bit_valid),
        .cmp_valid   (cmp_valid),
        .bit_data    (bit_data),
        .cmp_data    (cmp_data),
        .bit_dest    (bit_dest),
        .cmp_dest    (cmp_dest),
        .result_valid(result_valid),
        .result_data (result_data),
        .result_dest (result_dest)
    );

endmodule

// ==== tests/exec_lane_tb.sv ====
`timescale 1ns/1ps

module exec_lane_tb;

    localparam int PIPELINE_DEPTH  = 5;
    localparam int CLK_PERIOD      = 20;
    localparam int TRACE_LINES     = 30;
    localparam int FIELDS          = 6;
    localparam int WATCHDOG_CYCLES = 20 * TRACE_LINES * PIPELINE_DEPTH;

    logic                    clock = 1'b0;
    logic                    rst_n;
    logic                    op_valid;
    alu_isa_pkg::opcode_t    op_code;
    alu_data_pkg::word_t     operand_a;
    alu_data_pkg::word_t     operand_b;
    alu_data_pkg::reg_addr_t op_dest;
    logic                    op_ready;
    logic                    result_valid;
    alu_data_pkg::word_t     result_data;
    alu_data_pkg::reg_addr_t result_dest;
    logic                    result_ready;

    logic [31:0] trace_mem [TRACE_LINES * FIELDS];
    logic [39:0] expected_q [$];
    logic [31:0] rng;
    int          next_line;
    int          edge_count;
    int          first_accept_edge;
    logic        first_result_seen;
    int          checked;
    int          errors;

    exec_lane #(
        .PIPELINE_DEPTH(PIPELINE_DEPTH)
    ) uut (
        .clock       (clock),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .op_code     (op_code),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .op_dest     (op_dest),
        .op_ready    (op_ready),
        .result_valid(result_valid),
        .result_data (result_data),
        .result_dest (result_dest),
        .result_ready(result_ready)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] trace_field(input int line, input int col);
        return trace_mem[line * FIELDS + col];
    endfunction

    // New inputs go out 1 ns after the edge, so they are stable at the next edge
    task automatic drive_inputs();
        if (next_line < TRACE_LINES) begin
            op_valid  = 1'b1;
            op_code   = alu_isa_pkg::opcode_t'(5'(trace_field(next_line, 0)));
            operand_a = trace_field(next_line, 1);
            operand_b = trace_field(next_line, 2);
            op_dest   = 8'(trace_field(next_line, 3));
        end else begin
            op_valid  = 1'b0;
            op_code   = alu_isa_pkg::NOP;
            operand_a = '0;
            operand_b = '0;
            op_dest   = '0;
        end
        rng = lcg_next(rng);
        // No stalls until the first result has been taken
        if (next_line <= 5) begin
            result_ready = 1'b1;
        end else begin
            result_ready = (rng[17:16] != 2'b00);
        end
    endtask

    task automatic accept_line();
        if (next_line == 0) begin
            first_accept_edge = edge_count + 1;
        end
        if (trace_field(next_line, 4) != 32'd0) begin
            expected_q.push_back({8'(trace_field(next_line, 3)), trace_field(next_line, 5)});
        end
        next_line++;
    endtask

    task automatic check_result();
        logic [39:0] expected;
        int          latency;
        latency = edge_count + 1 - first_accept_edge;
        assert (expected_q.size() > 0) else begin
            $display("Unexpected result at time %0t: register %h got data %h with none expected",
                     $time, result_dest, result_data);
            errors++;
        end
        if (expected_q.size() > 0) begin
            expected = expected_q.pop_front();
            checked++;
            assert (result_dest == expected[39:32]) else begin
                $display("ERR time=%0t result_dest got=%h exp=%h",
                         $time, result_dest, expected[39:32]);
                errors++;
            end
            assert (result_data == expected[31:0]) else begin
                $display("ERR time=%0t result_data got=%h exp=%h",
                         $time, result_data, expected[31:0]);
                errors++;
            end
        end
        // The edge that takes the first result lies PIPELINE_DEPTH edges after its accept edge
        if (!first_result_seen) begin
            first_result_seen = 1'b1;
            assert (latency == PIPELINE_DEPTH) else begin
                $display("ERR time=%0t result_latency got=%0d exp=%0d",
                         $time, latency, PIPELINE_DEPTH);
                errors++;
            end
        end
    endtask

    // Handshakes are judged at the falling edge, half a period before the edge that commits them
    task automatic run_cycle();
        @(negedge clock);
        assert (op_ready == result_ready) else begin
            $display("ERR time=%0t op_ready got=%b exp=%b", $time, op_ready, result_ready);
            errors++;
        end
        if (result_valid && result_ready) begin
            check_result();
        end
        if (op_valid && op_ready) begin
            accept_line();
        end
        @(posedge clock);
        edge_count++;
        #1;
        drive_inputs();
    endtask

    initial begin
        $readmemh("tests/exec_lane_trace.txt", trace_mem);
        rst_n             = 1'b0;
        op_valid          = 1'b0;
        op_code           = alu_isa_pkg::NOP;
        operand_a         = '0;
        operand_b         = '0;
        op_dest           = '0;
        result_ready      = 1'b0;
        rng               = 32'd81;
        next_line         = 0;
        edge_count        = 0;
        first_accept_edge = 0;
        first_result_seen = 1'b0;
        checked           = 0;
        errors            = 0;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;
        drive_inputs();
        while (!(next_line == TRACE_LINES && expected_q.size() == 0)) begin
            run_cycle();
        end
        // A few more cycles catch any result that should not exist
        repeat (PIPELINE_DEPTH + 2) run_cycle();
        $display("Checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired with %0d results still missing, %0d of %0d lines issued",
                 expected_q.size(), next_line, TRACE_LINES);
        $display("Checked %0d results, %0d errors", checked, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tests/exec_lane_trace.txt ====
// Columns: opcode operand_a operand_b dest expect_valid expect_data, all hex
// One instruction per line, expect_valid 0 means the slot gives no result
01 3F800000 12345678 03 1 3F800000
02 DEADBEEF 40490FDB 07 1 40490FDB
09 F0F0F0F0 FF00FF00 0A 1 F000F000
0A F0F0F0F0 0F0F0000 0B 1 FFFFF0F0
0B AAAA5555 FFFF0000 0C 1 55555555
0C 12345678 00000000 0D 1 EDCBA987
0D FFFFFFFF 00000000 0E 1 00000020
0D 80000001 00000000 0F 1 00000002
0E C0490FDB 00000000 10 1 40490FDB
00 11111111 22222222 11 0 00000000
0F 00000001 00000000 12 1 00000001
0F 00020000 00000011 13 1 00000001
0F 7FFFFFFF 0000001F 14 1 00000000
10 00000000 FFFFFFE0 15 1 00000001
10 00000000 00000031 16 1 00020000
11 FFFFFFFF 0000003F 17 1 7FFFFFFF
1F 12345678 9ABCDEF0 18 0 00000000
03 3F800000 BF800000 19 1 00000001
03 BF800000 3F800000 1A 1 00000000
04 C0000000 BF800000 1B 1 00000001
05 00000000 80000000 1C 1 00000001
06 00000000 80000000 1D 1 00000000
04 80000000 00000000 1E 1 00000001
06 40400000 40000000 1F 1 00000001
07 40A00000 40400000 20 1 40400000
07 C0A00000 40400000 21 1 C0A00000
08 C0A00000 C0400000 22 1 C0400000
08 80000000 00000000 23 1 80000000
12 00000000 00000000 24 0 00000000
03 C0400000 C0A00000 25 1 00000001

// ==== list.f ====
design/alu_data_pkg.sv
design/alu_isa_pkg.sv
design/delay_line.sv
design/bitwise_unit.sv
design/float_compare_unit.sv
design/writeback_select.sv
design/exec_lane.sv
tests/exec_lane_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the exec_lane testbench with Verilator, runs it and checks the outcome

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module exec_lane_tb -o sim_exec_lane
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_exec_lane)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
